// File: Bender.yml
package:
  name: posit_ppu

sources:
  - files:
      - logic/posit_pkg.sv
      - logic/ppu_pkg.sv
      - logic/posit_decode.sv
      - logic/core_add_sub.sv
      - logic/core_mul.sv
      - logic/core_op.sv
      - logic/posit_encode.sv
      - logic/ppu_top.sv
  - target: test
    files:
      - testbench/tb_ppu.sv

// File: flist.f
logic/posit_pkg.sv
logic/ppu_pkg.sv
logic/posit_decode.sv
logic/core_add_sub.sv
logic/core_mul.sv
logic/core_op.sv
logic/posit_encode.sv
logic/ppu_top.sv
testbench/tb_ppu.sv

// File: logic/core_add_sub.sv
`timescale 1ns/1ps

module core_add_sub (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        advance_i,
  input  logic                                        sub_i,
  input  ppu_pkg::fir_t                               fir1_i,
  input  ppu_pkg::fir_t                               fir2_i,
  output logic                                        sign_o,
  output posit_pkg::exponent_t                        te_o,
  output logic [ppu_pkg::MANT_ADD_RESULT_SIZE-1:0]    mant_o,
  output logic                                        frac_truncated_o
);

  import posit_pkg::*;
  import ppu_pkg::*;

  logic                                     sign2, swap, eff_sub, far;
  logic                                     big_sign, small_sign;
  exponent_t                                big_te, small_te, te_next, lz;
  logic [MANT_SIZE-1:0]                     big_mant, small_mant;
  logic [TE_BITS:0]                         diff;
  logic [MANT_ADD_RESULT_SIZE+MANT_SIZE:0]  wide;
  logic [MANT_ADD_RESULT_SIZE:0]            big_al, small_al;
  logic                                     small_sticky, lz_done;
  logic [MANT_ADD_RESULT_SIZE+1:0]          sum, norm;

  always_comb begin
    sign2 = fir2_i.sign ^ sub_i;
    swap  = (fir2_i.total_exponent > fir1_i.total_exponent) ||
            (fir2_i.total_exponent == fir1_i.total_exponent && fir2_i.mant > fir1_i.mant);

    big_sign   = swap ? sign2 : fir1_i.sign;
    big_te     = swap ? fir2_i.total_exponent : fir1_i.total_exponent;
    big_mant   = swap ? fir2_i.mant : fir1_i.mant;
    small_sign = swap ? fir1_i.sign : sign2;
    small_te   = swap ? fir1_i.total_exponent : fir2_i.total_exponent;
    small_mant = swap ? fir1_i.mant : fir2_i.mant;
    eff_sub    = big_sign ^ small_sign;

    diff = {big_te[TE_BITS-1], big_te} - {small_te[TE_BITS-1], small_te};

    // the bits that fall below the guard and round positions collapse into a sticky bit
    wide         = {1'b0, small_mant, 2'b00, {MANT_SIZE{1'b0}}} >> diff;
    far          = diff >= (MANT_ADD_RESULT_SIZE + MANT_SIZE);
    small_sticky = far ? |small_mant : |wide[MANT_SIZE-1:0];
    small_al     = wide[MANT_ADD_RESULT_SIZE+MANT_SIZE -: MANT_ADD_RESULT_SIZE+1];
    big_al       = {1'b0, big_mant, 2'b00};

    sum = eff_sub ? {big_al, 1'b0} - {small_al, small_sticky}
                  : {big_al, 1'b0} + {small_al, small_sticky};

    lz      = '0;
    lz_done = 1'b0;
    for (int i = MANT_ADD_RESULT_SIZE; i >= 0; i--) begin
      if (!lz_done && !sum[i]) begin
        lz = lz + 1;
      end else begin
        lz_done = 1'b1;
      end
    end

    if (sum[MANT_ADD_RESULT_SIZE+1]) begin
      norm    = {1'b0, sum[MANT_ADD_RESULT_SIZE+1:2], |sum[1:0]};  // carry out, shift right once
      te_next = big_te + 1;
    end else begin
      norm    = sum << lz;
      te_next = big_te - lz;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sign_o           <= 1'b0;
      te_o             <= '0;
      mant_o           <= '0;
      frac_truncated_o <= 1'b0;
    end else if (advance_i) begin
      sign_o           <= big_sign;
      te_o             <= te_next;
      mant_o           <= norm[MANT_ADD_RESULT_SIZE+1:2];
      frac_truncated_o <= |norm[1:0];
    end
  end

endmodule

// File: logic/core_mul.sv
`timescale 1ns/1ps

module core_mul (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        advance_i,
  input  ppu_pkg::fir_t                               fir1_i,
  input  ppu_pkg::fir_t                               fir2_i,
  output logic                                        sign_o,
  output posit_pkg::exponent_t                        te_o,
  output logic [ppu_pkg::MANT_MUL_RESULT_SIZE-1:0]    mant_o,
  output logic                                        frac_truncated_o
);

  import posit_pkg::*;
  import ppu_pkg::*;

  logic [MANT_MUL_RESULT_SIZE-1:0] prod;
  logic [MANT_MUL_RESULT_SIZE-1:0] mant_next;
  exponent_t                       te_next;
  logic                            trunc_next;

  always_comb begin
    prod = fir1_i.mant * fir2_i.mant;

    // both mantissas lie in [1,2) so the product needs at most one right shift
    if (prod[MANT_MUL_RESULT_SIZE-1]) begin
      mant_next  = prod >> 1;
      trunc_next = prod[0];
      te_next    = fir1_i.total_exponent + fir2_i.total_exponent + 1;
    end else begin
      mant_next  = prod;
      trunc_next = 1'b0;
      te_next    = fir1_i.total_exponent + fir2_i.total_exponent;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sign_o           <= 1'b0;
      te_o             <= '0;
      mant_o           <= '0;
      frac_truncated_o <= 1'b0;
    end else if (advance_i) begin
      sign_o           <= fir1_i.sign ^ fir2_i.sign;
      te_o             <= te_next;
      mant_o           <= mant_next;
      frac_truncated_o <= trunc_next;
    end
  end

endmodule

// File: logic/core_op.sv
`timescale 1ns/1ps

module core_op (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  valid_i,
  output logic                                  ready_o,
  input  ppu_pkg::operation_e                   op_i,
  input  ppu_pkg::fir_t                         fir1_i,
  input  ppu_pkg::fir_t                         fir2_i,
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output logic                                  sign_o,
  output posit_pkg::exponent_t                  te_o,
  output logic [posit_pkg::FRAC_FULL_SIZE-1:0]  frac_o,
  output logic                                  sticky_o,
  output logic                                  nar_o,
  output logic                                  zero_o
);

  import posit_pkg::*;
  import ppu_pkg::*;

  logic                            valid_q, advance;
  operation_e                      op_q;
  logic                            nar_q, zero_q, zero_res;
  logic                            sign_add, sign_mul, trunc_add, trunc_mul;
  exponent_t                       te_add, te_mul;
  logic [MANT_ADD_RESULT_SIZE-1:0] mant_add;
  logic [MANT_MUL_RESULT_SIZE-1:0] mant_mul;
  logic [FRAC_FULL_SIZE-1:0]       frac_sel;

  assign ready_o = !valid_q || ready_i;
  assign advance = valid_i && ready_o;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // operation and special flags travel with the unit results
  always_ff @(posedge clk_i) begin
    if (advance) begin
      op_q   <= op_i;
      nar_q  <= fir1_i.is_nar || fir2_i.is_nar;
      zero_q <= fir1_i.is_zero || fir2_i.is_zero;
    end
  end

  // zero operands reach the adder with an empty mantissa, so the other one passes through
  core_add_sub u_add_sub (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .advance_i        (advance),
    .sub_i            (op_i == SUB),
    .fir1_i           (fir1_i),
    .fir2_i           (fir2_i),
    .sign_o           (sign_add),
    .te_o             (te_add),
    .mant_o           (mant_add),
    .frac_truncated_o (trunc_add)
  );

  core_mul u_mul (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .advance_i        (advance),
    .fir1_i           (fir1_i),
    .fir2_i           (fir2_i),
    .sign_o           (sign_mul),
    .te_o             (te_mul),
    .mant_o           (mant_mul),
    .frac_truncated_o (trunc_mul)
  );

  always_comb begin
    if (op_q == MUL) begin
      sign_o   = sign_mul;
      te_o     = te_mul;
      frac_sel = {mant_mul, {(FRAC_FULL_SIZE - MANT_MUL_RESULT_SIZE){1'b0}}};
      sticky_o = trunc_mul;
      zero_res = zero_q;
    end else begin
      sign_o   = sign_add;
      te_o     = te_add;
      frac_sel = {mant_add, {(FRAC_FULL_SIZE - MANT_ADD_RESULT_SIZE){1'b0}}};
      sticky_o = trunc_add;
      zero_res = mant_add == '0;  // exact cancellation or two zero operands
    end
  end

  assign frac_o = frac_sel << 2;  // the two integer bits go, the hidden bit is implied
  assign nar_o  = nar_q;
  assign zero_o = zero_res && !nar_q;

  // a stalled result must not move until the encoder takes it
  a_hold_under_stall: assert property (
    @(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable({sign_o, te_o, frac_o, sticky_o, nar_o, zero_o})
  );

endmodule

// File: logic/posit_decode.sv
`timescale 1ns/1ps

module posit_decode (
  input  posit_pkg::posit_t posit_i,
  output ppu_pkg::fir_t     fir_o
);

  import posit_pkg::*;
  import ppu_pkg::*;

  logic                     sign;
  posit_t                   mag;
  logic [N-2:0]             body;
  logic [N-2:0]             rem;
  logic [$clog2(N)-1:0]     run;
  logic                     run_done;
  logic signed [TE_BITS-2:0] run_ext;
  logic signed [TE_BITS-2:0] k;
  fir_t                     fir;

  always_comb begin
    sign = posit_i[N-1];
    mag  = sign ? -posit_i : posit_i;  // negative posits are stored in two's complement
    body = mag[N-2:0];

    // length of the regime run, measured from the bit after the sign
    run      = '0;
    run_done = 1'b0;
    for (int i = N - 2; i >= 0; i--) begin
      if (!run_done && body[i] == body[N-2]) begin
        run = run + 1'b1;
      end else begin
        run_done = 1'b1;
      end
    end

    run_ext = (TE_BITS-1)'(run);
    k       = body[N-2] ? run_ext - (TE_BITS-1)'(1) : -run_ext;

    // drop the regime run and its terminating bit
    rem = (body << run) << 1;

    fir.sign           = sign;
    fir.total_exponent = {k, rem[N-2]};  // regime times two plus the exponent bit
    fir.mant           = {1'b1, rem[N-3 -: MANT_SIZE-1]};
    fir.is_zero        = posit_i == '0;
    fir.is_nar         = posit_i == {1'b1, {(N-1){1'b0}}};

    // a zero gets an empty mantissa and the lowest exponent so it never wins an alignment
    if (fir.is_zero || fir.is_nar) begin
      fir.sign           = 1'b0;
      fir.total_exponent = {1'b1, {(TE_BITS-1){1'b0}}};
      fir.mant           = '0;
    end
  end

  assign fir_o = fir;

endmodule

// File: logic/posit_encode.sv
`timescale 1ns/1ps

module posit_encode (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  valid_i,
  output logic                                  ready_o,
  input  logic                                  sign_i,
  input  posit_pkg::exponent_t                  te_i,
  input  logic [posit_pkg::FRAC_FULL_SIZE-1:0]  frac_i,
  input  logic                                  sticky_i,
  input  logic                                  nar_i,
  input  logic                                  zero_i,
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output posit_pkg::posit_t                     result_o
);

  import posit_pkg::*;

  exponent_t                     k;
  logic [TE_BITS-1:0]            shamt;
  logic [N+ES+FRAC_FULL_SIZE:0]  v, v_sh;
  logic [N-2:0]                  body, body_r;
  logic                          guard, rest, round_up;
  posit_t                        result_next, result_q;
  logic                          valid_q;

  always_comb begin
    k     = te_i >>> ES;
    shamt = k[TE_BITS-1] ? ~k : k;  // run length minus one

    // the arithmetic shift stretches the regime: ones for k >= 0, zeros below
    v    = {~k[TE_BITS-1], k[TE_BITS-1], te_i[ES-1:0], frac_i, {(N-1){1'b0}}};
    v_sh = $signed(v) >>> shamt;

    body     = v_sh[N+ES+FRAC_FULL_SIZE -: N-1];
    guard    = v_sh[ES+FRAC_FULL_SIZE+1];
    rest     = |v_sh[ES+FRAC_FULL_SIZE:0] || sticky_i;
    round_up = guard && (body[0] || rest);
    body_r   = body + round_up;

    // saturate so that a finite nonzero value never turns into zero or NaR
    if (k >= N - 2) begin
      body_r = '1;
    end else if (k < -(N - 2)) begin
      body_r = {{(N-2){1'b0}}, 1'b1};
    end

    result_next = sign_i ? -{1'b0, body_r} : {1'b0, body_r};
    if (nar_i) begin
      result_next = {1'b1, {(N-1){1'b0}}};
    end else if (zero_i) begin
      result_next = '0;
    end
  end

  assign ready_o  = !valid_q || ready_i;
  assign valid_o  = valid_q;
  assign result_o = result_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      result_q <= result_next;
    end
  end

  // a finite nonzero item never comes out as zero or NaR
  a_nonzero_not_zero_or_nar: assert property (
    @(posedge clk_i) disable iff (reset_i)
    valid_i && ready_o && !nar_i && !zero_i |=>
      result_o != '0 && result_o != {1'b1, {(N-1){1'b0}}}
  );

endmodule

// File: logic/posit_pkg.sv
package posit_pkg;

  // posit16 with a single exponent bit
  localparam int N              = 16;
  localparam int ES             = 1;

  // total exponent covers the regime and the exponent bit, with headroom for a product
  localparam int TE_BITS        = 7;

  // hidden bit plus the widest fraction a posit16 can carry
  localparam int MANT_SIZE      = 13;

  localparam int FRAC_FULL_SIZE = 28;  // fraction width seen by the encoder

  typedef logic [N-1:0] posit_t;

  typedef logic signed [TE_BITS-1:0] exponent_t;

endpackage

// File: logic/ppu_pkg.sv
package ppu_pkg;

  import posit_pkg::*;

  typedef enum logic [1:0] {
    ADD = 2'b00,
    SUB = 2'b01,
    MUL = 2'b10
  } operation_e;

  // decoded posit, one field per component
  typedef struct packed {
    logic                   sign;
    exponent_t              total_exponent;
    logic [MANT_SIZE-1:0]   mant;            // hidden bit on top
    logic                   is_zero;
    logic                   is_nar;
  } fir_t;

  // carry, hidden bit, fraction and one guard bit
  localparam int MANT_ADD_RESULT_SIZE = MANT_SIZE + 2;

  // full product, two integer bits on top
  localparam int MANT_MUL_RESULT_SIZE = 2 * MANT_SIZE;

endpackage

// File: logic/ppu_top.sv
`timescale 1ns/1ps

module ppu_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  ppu_pkg::operation_e op_i,
  input  posit_pkg::posit_t   posit_a_i,
  input  posit_pkg::posit_t   posit_b_i,
  output logic                valid_o,
  input  logic                ready_i,
  output posit_pkg::posit_t   result_o
);

  import posit_pkg::*;
  import ppu_pkg::*;

  fir_t                      fir_a, fir_b;
  logic                      s1_valid, s1_ready;
  logic                      s1_sign, s1_sticky, s1_nar, s1_zero;
  exponent_t                 s1_te;
  logic [FRAC_FULL_SIZE-1:0] s1_frac;

  posit_decode u_decode_a (
    .posit_i (posit_a_i),
    .fir_o   (fir_a)
  );

  posit_decode u_decode_b (
    .posit_i (posit_b_i),
    .fir_o   (fir_b)
  );

  core_op u_core_op (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .op_i     (op_i),
    .fir1_i   (fir_a),
    .fir2_i   (fir_b),
    .valid_o  (s1_valid),
    .ready_i  (s1_ready),
    .sign_o   (s1_sign),
    .te_o     (s1_te),
    .frac_o   (s1_frac),
    .sticky_o (s1_sticky),
    .nar_o    (s1_nar),
    .zero_o   (s1_zero)
  );

  posit_encode u_encode (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (s1_valid),
    .ready_o  (s1_ready),
    .sign_i   (s1_sign),
    .te_i     (s1_te),
    .frac_i   (s1_frac),
    .sticky_i (s1_sticky),
    .nar_i    (s1_nar),
    .zero_i   (s1_zero),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .result_o (result_o)
  );

endmodule

// File: testbench/tb_ppu.sv
`timescale 1ns/1ps

module tb_ppu;

  import posit_pkg::*;
  import ppu_pkg::*;

  // posit16 literals with es = 1
  localparam logic [15:0] P_ZERO     = 16'h0000;
  localparam logic [15:0] P_ONE      = 16'h4000;
  localparam logic [15:0] P_TWO      = 16'h5000;
  localparam logic [15:0] P_HALF     = 16'h3000;
  localparam logic [15:0] P_ONE_HALF = 16'h4800;
  localparam logic [15:0] P_NEG_ONE  = 16'hC000;
  localparam logic [15:0] P_NAR      = 16'h8000;
  localparam logic [15:0] P_MAXPOS   = 16'h7FFF;
  localparam logic [15:0] P_MINPOS   = 16'h0001;
  localparam logic [15:0] P_2_25     = 16'h5200;  // 0 10 1 001000000000, 2 * 1.125

  localparam int RESET_CYCLES   = 10;
  localparam int N_OPS_TOTAL    = 4 + 3 + 7 + 2 * 14;  // directed groups plus two full table runs
  localparam int TIMEOUT_CYCLES = 4 * N_OPS_TOTAL + RESET_CYCLES;

  logic        clk_i;
  logic        reset_i;
  logic        valid_i;
  logic        ready_o;
  operation_e  op_i;
  posit_t      posit_a_i;
  posit_t      posit_b_i;
  logic        valid_o;
  logic        ready_i;
  posit_t      result_o;

  logic [31:0] lfsr_state = 32'h79ba;

  // operations waiting to be streamed, with the result each one must give
  operation_e  op_q[$];
  logic [15:0] a_q[$];
  logic [15:0] b_q[$];
  logic [15:0] exp_q[$];

  ppu_top dut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .valid_i   (valid_i),
    .ready_o   (ready_o),
    .op_i      (op_i),
    .posit_a_i (posit_a_i),
    .posit_b_i (posit_b_i),
    .valid_o   (valid_o),
    .ready_i   (ready_i),
    .result_o  (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // fibonacci lfsr with taps 32, 22, 2 and 1
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // a posit is negated by its two's complement
  function automatic logic [15:0] negate(input logic [15:0] p);
    return -p;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "a response differed from its expected value");
    end
  endtask

  task automatic push_op(input operation_e op, input logic [15:0] a, input logic [15:0] b,
                         input logic [15:0] expected);
    op_q.push_back(op);
    a_q.push_back(a);
    b_q.push_back(b);
    exp_q.push_back(expected);
  endtask

  task automatic add_sub_table();
    push_op(ADD, P_ONE, P_ONE, P_TWO);
    push_op(SUB, P_TWO, P_HALF, P_ONE_HALF);
    push_op(SUB, P_ONE, P_ONE, P_ZERO);
    push_op(ADD, P_NEG_ONE, P_TWO, P_ONE);
  endtask

  task automatic mul_table();
    push_op(MUL, P_TWO, P_HALF, P_ONE);
    push_op(MUL, P_NEG_ONE, P_ONE_HALF, negate(P_ONE_HALF));
    push_op(MUL, P_ONE_HALF, P_ONE_HALF, P_2_25);
  endtask

  task automatic special_table();
    push_op(ADD, P_NAR, P_ONE, P_NAR);
    push_op(MUL, P_ZERO, P_NAR, P_NAR);
    push_op(SUB, P_ONE_HALF, P_NAR, P_NAR);
    push_op(MUL, P_ONE_HALF, P_ZERO, P_ZERO);
    push_op(SUB, P_ZERO, P_ONE_HALF, negate(P_ONE_HALF));
    push_op(MUL, P_MAXPOS, P_MAXPOS, P_MAXPOS);  // saturates instead of reaching NaR
    push_op(MUL, P_MINPOS, P_MINPOS, P_MINPOS);  // saturates instead of reaching zero
  endtask

  // sends every queued operation and checks the results in order, one loop pass per clock
  task automatic stream_ops(input bit random_gaps);
    int sent;
    int got;
    int cyc;
    int accept_cycle[$];
    bit accepted;
    sent = 0;
    got  = 0;
    cyc  = 0;
    while (got < exp_q.size()) begin
      @(posedge clk_i);
      cyc++;
      accepted = valid_i && ready_o;
      if (accepted) begin
        accept_cycle.push_back(cyc);
        sent++;
      end
      if (valid_o && ready_i) begin
        check_value("result_o", result_o, exp_q[got]);
        if (!random_gaps) begin
          check_value("latency", cyc - accept_cycle[got], 2);  // two stage registers
        end
        got++;
      end
      ready_i <= random_gaps ? next_random_bit() : 1'b1;
      // a pending request keeps its data until it is taken
      if (!valid_i || accepted) begin
        if (sent < op_q.size() && (!random_gaps || next_random_bit())) begin
          valid_i   <= 1'b1;
          op_i      <= op_q[sent];
          posit_a_i <= a_q[sent];
          posit_b_i <= b_q[sent];
        end else begin
          valid_i <= 1'b0;
        end
      end
    end
    ready_i <= 1'b1;
    op_q.delete();
    a_q.delete();
    b_q.delete();
    exp_q.delete();
  endtask

  task automatic check_reset_state();
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_value("valid_o", valid_o, 1'b0);
    check_value("ready_o", ready_o, 1'b1);
  endtask

  task automatic verify_add_sub();
    add_sub_table();
    stream_ops(1'b0);
  endtask

  task automatic verify_mul();
    mul_table();
    stream_ops(1'b0);
  endtask

  task automatic verify_specials();
    special_table();
    stream_ops(1'b0);
  endtask

  task automatic stream_with_stalls();
    add_sub_table();
    mul_table();
    special_table();
    stream_ops(1'b1);
  endtask

  task automatic stream_at_full_rate();
    add_sub_table();
    mul_table();
    special_table();
    stream_ops(1'b0);
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation timed out");
  end

  initial begin
    reset_i   = 1'b1;
    valid_i   = 1'b0;
    ready_i   = 1'b1;
    op_i      = ADD;
    posit_a_i = '0;
    posit_b_i = '0;

    check_reset_state();
    verify_add_sub();
    verify_mul();
    verify_specials();
    stream_with_stalls();
    stream_at_full_rate();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
